//--- hw/burst_map_pkg.sv
// Burst mapping bridge shared definitions
// Fixed bus widths and the packed request and write beat types that
// travel between the bridge, its top level and the testbench
package burst_map_pkg;

    // Word address width on both sides of the bridge
    localparam int ADDR_WIDTH = 16;

    // Data width of read and write beats
    localparam int DATA_WIDTH = 32;

    // One byte enable per data byte
    localparam int BYTE_EN_WIDTH = DATA_WIDTH / 8;

    // Read request fields that travel with rd_read
    // The burst count is kept apart since its width differs per side
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    address;
        logic [BYTE_EN_WIDTH-1:0] byteenable;
    } rd_req_t;

    // Payload of a single write beat
    // Address and burst count are separate ports, valid only on SOP
    typedef struct packed {
        logic [DATA_WIDTH-1:0]    writedata;
        logic [BYTE_EN_WIDTH-1:0] byteenable;
    } wr_beat_t;

endpackage

//--- hw/sop_tracker.sv
// Burst beat tracker
// Follows a stream of beats against their burst counts and flags the
// first beat (SOP) and last beat (EOP) of each burst
`timescale 1ns/10ps

module sop_tracker
#(
    parameter int BURST_CNT_WIDTH = 4
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flit_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop,
    output logic                       eop
);

    // Beats still owed by the open burst, zero when no burst is open
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    // With nothing open the next beat starts a new burst
    assign sop = (beats_left == '0);

    // A fresh one-beat burst ends at once, otherwise the count decides
    assign eop = sop ? (burstcount == BURST_CNT_WIDTH'(1)) :
                       (beats_left == BURST_CNT_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            // The SOP beat itself is counted, hence the minus one on load
            if (sop)
                beats_left <= burstcount - BURST_CNT_WIDTH'(1);
            else
                beats_left <= beats_left - BURST_CNT_WIDTH'(1);
        end
    end

endmodule

//--- hw/burst_gearbox.sv
// Burst count gearbox
// Takes one master address and burst count and hands them out as a series
// of slave bursts, each no longer than the slave maximum and, when natural
// alignment is on, a power of two that divides its start address
`timescale 1ns/10ps

module burst_gearbox
#(
    parameter int MASTER_BURST_WIDTH = 4,
    parameter int SLAVE_BURST_WIDTH  = 2,
    parameter int NATURAL_ALIGNMENT  = 1
)
(
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  m_new_req,
    input  logic [burst_map_pkg::ADDR_WIDTH-1:0]  m_addr,
    input  logic [MASTER_BURST_WIDTH-1:0]         m_burstcount,

    input  logic                                  s_accept_req,
    output logic                                  s_req_complete,
    output logic [burst_map_pkg::ADDR_WIDTH-1:0]  s_addr,
    output logic [SLAVE_BURST_WIDTH-1:0]          s_burstcount
);

    import burst_map_pkg::*;

    // Longest slave burst, expressed in master count width for arithmetic
    localparam logic [MASTER_BURST_WIDTH-1:0] SLAVE_MAX =
        MASTER_BURST_WIDTH'(1 << (SLAVE_BURST_WIDTH - 1));

    // Beats of the master burst not yet handed out, including the current piece
    logic [MASTER_BURST_WIDTH-1:0] beats_rem;
    // Start address of the current piece
    logic [ADDR_WIDTH-1:0]         next_addr;
    // Size of the current piece
    logic [MASTER_BURST_WIDTH-1:0] piece;

    always_comb
    begin
        logic [MASTER_BURST_WIDTH-1:0] step;
        logic [ADDR_WIDTH-1:0]         low_mask;

        piece = '0;
        if (NATURAL_ALIGNMENT != 0)
        begin
            // Walk the powers of two upward; both the remaining beats test
            // and the alignment test only get harder, so the last hit wins
            for (int i = 0; i < SLAVE_BURST_WIDTH; i++)
            begin
                step = MASTER_BURST_WIDTH'(1) << i;
                low_mask = ADDR_WIDTH'((1 << i) - 1);
                if ((beats_rem >= step) && ((next_addr & low_mask) == '0))
                    piece = step;
            end
        end
        else
        begin
            // No alignment rule, so any length up to the maximum is legal
            piece = (beats_rem > SLAVE_MAX) ? SLAVE_MAX : beats_rem;
        end
    end

    // The piece that uses up every remaining beat closes the master burst
    assign s_req_complete = (beats_rem == piece);
    assign s_addr = next_addr;
    assign s_burstcount = piece[SLAVE_BURST_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_rem <= '0;
        end
        else if (m_new_req)
        begin
            beats_rem <= m_burstcount;
        end
        else if (s_accept_req && !s_req_complete)
        begin
            beats_rem <= beats_rem - piece;
        end
    end

    // Address follows the same load and advance rules as the count
    always_ff @(posedge clk)
    begin
        if (m_new_req)
            next_addr <= m_addr;
        else if (s_accept_req && !s_req_complete)
            next_addr <= next_addr + ADDR_WIDTH'(piece);
    end

endmodule

//--- hw/burst_remap.sv
// Read and write burst splitting bridge
// Master bursts are broken into legal slave bursts by two gearboxes; read data
// flows back untouched and write beats pass through a single register stage
`timescale 1ns/10ps

module burst_remap
#(
    parameter int MASTER_BURST_WIDTH = 4,
    parameter int SLAVE_BURST_WIDTH  = 2,
    parameter int NATURAL_ALIGNMENT  = 1
)
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Master read
    input  logic                                  m_rd_read,
    input  burst_map_pkg::rd_req_t                m_rd_req,
    input  logic [MASTER_BURST_WIDTH-1:0]         m_rd_burstcount,
    output logic                                  m_rd_waitrequest,
    output logic [burst_map_pkg::DATA_WIDTH-1:0]  m_rd_readdata,
    output logic                                  m_rd_readdatavalid,

    // Master write
    input  logic                                  m_wr_write,
    input  logic [burst_map_pkg::ADDR_WIDTH-1:0]  m_wr_address,
    input  logic [MASTER_BURST_WIDTH-1:0]         m_wr_burstcount,
    input  burst_map_pkg::wr_beat_t               m_wr_beat,
    output logic                                  m_wr_waitrequest,

    // Slave read
    output logic                                  s_rd_read,
    output burst_map_pkg::rd_req_t                s_rd_req,
    output logic [SLAVE_BURST_WIDTH-1:0]          s_rd_burstcount,
    input  logic                                  s_rd_waitrequest,
    input  logic [burst_map_pkg::DATA_WIDTH-1:0]  s_rd_readdata,
    input  logic                                  s_rd_readdatavalid,

    // Slave write
    output logic                                  s_wr_write,
    output logic [burst_map_pkg::ADDR_WIDTH-1:0]  s_wr_address,
    output logic [SLAVE_BURST_WIDTH-1:0]          s_wr_burstcount,
    output burst_map_pkg::wr_beat_t               s_wr_beat,
    input  logic                                  s_wr_waitrequest,

    // Pulses on an accepted slave SOP whose burst ends a master burst
    output logic                                  expects_response
);

    import burst_map_pkg::*;

    logic                         rd_next;
    logic                         rd_complete;
    logic [ADDR_WIDTH-1:0]        rd_gb_addr;
    logic [BYTE_EN_WIDTH-1:0]     rd_byteenable;

    logic                         wr_complete;
    logic [ADDR_WIDTH-1:0]        wr_gb_addr;
    logic [SLAVE_BURST_WIDTH-1:0] wr_gb_burstcount;
    logic                         m_wr_sop;
    logic                         s_wr_sop;

    // Take a new master read when the slave bus is free or the last piece of
    // the current read is leaving this cycle
    assign rd_next = !s_rd_waitrequest && (!s_rd_read || rd_complete);
    assign m_rd_waitrequest = !rd_next;

    burst_gearbox
    #(
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT  (NATURAL_ALIGNMENT)
    )
    rd_gearbox
    (
        .clk            (clk),
        .reset          (reset),
        .m_new_req      (rd_next),
        .m_addr         (m_rd_req.address),
        .m_burstcount   (m_rd_burstcount),
        .s_accept_req   (!s_rd_waitrequest),
        .s_req_complete (rd_complete),
        .s_addr         (rd_gb_addr),
        .s_burstcount   (s_rd_burstcount)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            s_rd_read <= 1'b0;
        else if (rd_next)
            s_rd_read <= m_rd_read;
    end

    // Byte enables are not held by the gearbox and stay for every piece
    always_ff @(posedge clk)
    begin
        if (rd_next)
            rd_byteenable <= m_rd_req.byteenable;
    end

    assign s_rd_req = '{address: rd_gb_addr, byteenable: rd_byteenable};

    // Read data carries no burst framing
    assign m_rd_readdata = s_rd_readdata;
    assign m_rd_readdatavalid = s_rd_readdatavalid;

    // Writes move one for one, so the master stalls exactly when the slave does
    assign m_wr_waitrequest = s_wr_waitrequest;

    // A master SOP loads the gearbox in the same cycle its beat is registered,
    // so the first slave piece is ready when that beat shows on the slave
    burst_gearbox
    #(
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT  (NATURAL_ALIGNMENT)
    )
    wr_gearbox
    (
        .clk            (clk),
        .reset          (reset),
        .m_new_req      (m_wr_write && !s_wr_waitrequest && m_wr_sop),
        .m_addr         (m_wr_address),
        .m_burstcount   (m_wr_burstcount),
        .s_accept_req   (s_wr_write && !s_wr_waitrequest && s_wr_sop),
        .s_req_complete (wr_complete),
        .s_addr         (wr_gb_addr),
        .s_burstcount   (wr_gb_burstcount)
    );

    // Off SOP the burst count reads zero, which no real burst can carry
    // Downstream logic can therefore spot SOP beats from the bus alone
    assign s_wr_address = s_wr_sop ? wr_gb_addr : '0;
    assign s_wr_burstcount = s_wr_sop ? wr_gb_burstcount : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
            s_wr_write <= 1'b0;
        else if (!s_wr_waitrequest)
            s_wr_write <= m_wr_write;
    end

    always_ff @(posedge clk)
    begin
        if (!s_wr_waitrequest)
            s_wr_beat <= m_wr_beat;
    end

    assign expects_response = s_wr_write && !s_wr_waitrequest && s_wr_sop && wr_complete;

    sop_tracker
    #(
        .BURST_CNT_WIDTH (MASTER_BURST_WIDTH)
    )
    m_sop_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (m_wr_write && !m_wr_waitrequest),
        .burstcount (m_wr_burstcount),
        .sop        (m_wr_sop),
        .eop        ()
    );

    sop_tracker
    #(
        .BURST_CNT_WIDTH (SLAVE_BURST_WIDTH)
    )
    s_sop_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (s_wr_write && !s_wr_waitrequest),
        .burstcount (s_wr_burstcount),
        .sop        (s_wr_sop),
        .eop        ()
    );

endmodule

//--- hw/wr_resp_filter.sv
// Write response filter
// Keeps one flag per slave write burst in issue order and lets a slave write
// response through to the master only when its burst ended a master burst
`timescale 1ns/10ps

module wr_resp_filter
#(
    parameter int RESP_FIFO_DEPTH = 16
)
(
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  logic push_flag,
    input  logic s_resp_valid,
    output logic m_resp_valid,
    output logic full
);

    localparam int PTR_WIDTH = $clog2(RESP_FIFO_DEPTH);

    logic                 flags [RESP_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 push_en;
    logic                 pop;

    assign full = (count == (PTR_WIDTH + 1)'(RESP_FIFO_DEPTH));
    assign push_en = push && !full;
    // Slave responses come in burst order, one per burst already pushed
    assign pop = s_resp_valid && (count != '0);

    // The flag at the head belongs to the burst being answered now
    assign m_resp_valid = s_resp_valid && flags[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push_en)
            flags[wr_ptr] <= push_flag;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap by compare so any depth works
            if (push_en)
                wr_ptr <= (wr_ptr == PTR_WIDTH'(RESP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_WIDTH'(RESP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push_en, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/burst_map_top.sv
// Burst mapping bridge top level
// Joins the splitting bridge to the write response filter and stalls writes
// while the filter has no room for another burst flag
`timescale 1ns/10ps

module burst_map_top
#(
    parameter int MASTER_BURST_WIDTH = 4,
    parameter int SLAVE_BURST_WIDTH  = 2,
    parameter int NATURAL_ALIGNMENT  = 1,
    parameter int RESP_FIFO_DEPTH    = 16
)
(
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  m_rd_read,
    input  burst_map_pkg::rd_req_t                m_rd_req,
    input  logic [MASTER_BURST_WIDTH-1:0]         m_rd_burstcount,
    output logic                                  m_rd_waitrequest,
    output logic [burst_map_pkg::DATA_WIDTH-1:0]  m_rd_readdata,
    output logic                                  m_rd_readdatavalid,
    input  logic                                  m_wr_write,
    input  logic [burst_map_pkg::ADDR_WIDTH-1:0]  m_wr_address,
    input  logic [MASTER_BURST_WIDTH-1:0]         m_wr_burstcount,
    input  burst_map_pkg::wr_beat_t               m_wr_beat,
    output logic                                  m_wr_waitrequest,
    output logic                                  m_wr_writeresponsevalid,

    output logic                                  s_rd_read,
    output burst_map_pkg::rd_req_t                s_rd_req,
    output logic [SLAVE_BURST_WIDTH-1:0]          s_rd_burstcount,
    input  logic                                  s_rd_waitrequest,
    input  logic [burst_map_pkg::DATA_WIDTH-1:0]  s_rd_readdata,
    input  logic                                  s_rd_readdatavalid,
    output logic                                  s_wr_write,
    output logic [burst_map_pkg::ADDR_WIDTH-1:0]  s_wr_address,
    output logic [SLAVE_BURST_WIDTH-1:0]          s_wr_burstcount,
    output burst_map_pkg::wr_beat_t               s_wr_beat,
    input  logic                                  s_wr_waitrequest,
    input  logic                                  s_wr_writeresponsevalid
);

    logic bridge_wr_write;
    logic bridge_wr_waitrequest;
    logic expects_response;
    logic resp_full;

    // A full flag FIFO looks like slave back-pressure to the bridge
    assign bridge_wr_waitrequest = s_wr_waitrequest || resp_full;
    // The slave must not take a beat that the bridge is still holding
    assign s_wr_write = bridge_wr_write && !resp_full;

    burst_remap
    #(
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT  (NATURAL_ALIGNMENT)
    )
    remap
    (
        .clk                (clk),
        .reset              (reset),
        .m_rd_read          (m_rd_read),
        .m_rd_req           (m_rd_req),
        .m_rd_burstcount    (m_rd_burstcount),
        .m_rd_waitrequest   (m_rd_waitrequest),
        .m_rd_readdata      (m_rd_readdata),
        .m_rd_readdatavalid (m_rd_readdatavalid),
        .m_wr_write         (m_wr_write),
        .m_wr_address       (m_wr_address),
        .m_wr_burstcount    (m_wr_burstcount),
        .m_wr_beat          (m_wr_beat),
        .m_wr_waitrequest   (m_wr_waitrequest),
        .s_rd_read          (s_rd_read),
        .s_rd_req           (s_rd_req),
        .s_rd_burstcount    (s_rd_burstcount),
        .s_rd_waitrequest   (s_rd_waitrequest),
        .s_rd_readdata      (s_rd_readdata),
        .s_rd_readdatavalid (s_rd_readdatavalid),
        .s_wr_write         (bridge_wr_write),
        .s_wr_address       (s_wr_address),
        .s_wr_burstcount    (s_wr_burstcount),
        .s_wr_beat          (s_wr_beat),
        .s_wr_waitrequest   (bridge_wr_waitrequest),
        .expects_response   (expects_response)
    );

    // Every accepted slave SOP pushes a flag; a nonzero burst count marks SOP
    wr_resp_filter
    #(
        .RESP_FIFO_DEPTH (RESP_FIFO_DEPTH)
    )
    resp_filter
    (
        .clk          (clk),
        .reset        (reset),
        .push         (s_wr_write && !bridge_wr_waitrequest && (s_wr_burstcount != '0)),
        .push_flag    (expects_response),
        .s_resp_valid (s_wr_writeresponsevalid),
        .m_resp_valid (m_wr_writeresponsevalid),
        .full         (resp_full)
    );

endmodule

//--- sim/burst_map_assert.sv
// Slave side burst legality checks
// Bound into the bridge, flags any slave burst that is empty, too long
// or not naturally aligned to its own size
`timescale 1ns/10ps

module burst_map_assert
#(
    parameter int SLAVE_BURST_WIDTH = 2,
    parameter int NATURAL_ALIGNMENT = 1
)
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 s_rd_read,
    input  burst_map_pkg::rd_req_t               s_rd_req,
    input  logic [SLAVE_BURST_WIDTH-1:0]         s_rd_burstcount,
    input  logic                                 s_rd_waitrequest,
    input  logic                                 s_wr_write,
    input  logic [burst_map_pkg::ADDR_WIDTH-1:0] s_wr_address,
    input  logic [SLAVE_BURST_WIDTH-1:0]         s_wr_burstcount,
    input  logic                                 s_wr_waitrequest
);

    import burst_map_pkg::*;

    localparam int SLAVE_MAX = 1 << (SLAVE_BURST_WIDTH - 1);

    logic rd_take;
    logic wr_sop_take;

    assign rd_take = s_rd_read && !s_rd_waitrequest;
    // Off SOP the bridge shows a zero burst count, so nonzero marks SOP
    assign wr_sop_take = s_wr_write && !s_wr_waitrequest && (s_wr_burstcount != '0);

    // Every accepted read piece carries a legal length
    rd_count_legal: assert property (@(posedge clk) disable iff (reset)
        rd_take |-> (s_rd_burstcount != '0) && (int'(s_rd_burstcount) <= SLAVE_MAX))
        else $error("slave read burst count out of range");

    // The piece start is a multiple of the piece length
    rd_aligned: assert property (@(posedge clk) disable iff (reset)
        rd_take && (NATURAL_ALIGNMENT != 0) |->
            ((s_rd_req.address & ADDR_WIDTH'(s_rd_burstcount - 1'b1)) == '0))
        else $error("slave read burst not aligned");

    wr_count_legal: assert property (@(posedge clk) disable iff (reset)
        wr_sop_take |-> int'(s_wr_burstcount) <= SLAVE_MAX)
        else $error("slave write burst count out of range");

    wr_aligned: assert property (@(posedge clk) disable iff (reset)
        wr_sop_take && (NATURAL_ALIGNMENT != 0) |->
            ((s_wr_address & ADDR_WIDTH'(s_wr_burstcount - 1'b1)) == '0))
        else $error("slave write burst not aligned");

endmodule

bind burst_remap burst_map_assert
#(
    .SLAVE_BURST_WIDTH (SLAVE_BURST_WIDTH),
    .NATURAL_ALIGNMENT (NATURAL_ALIGNMENT)
)
legality_checks
(
    .clk              (clk),
    .reset            (reset),
    .s_rd_read        (s_rd_read),
    .s_rd_req         (s_rd_req),
    .s_rd_burstcount  (s_rd_burstcount),
    .s_rd_waitrequest (s_rd_waitrequest),
    .s_wr_write       (s_wr_write),
    .s_wr_address     (s_wr_address),
    .s_wr_burstcount  (s_wr_burstcount),
    .s_wr_waitrequest (s_wr_waitrequest)
);

//--- sim/tb_top.sv
// Burst mapping bridge testbench
// Random read and write bursts from an LFSR against a memory slave model
// with random back-pressure, checked against a reference memory
`timescale 1ns/10ps

module tb_top;

    import burst_map_pkg::*;

    localparam int MBW       = 4;
    localparam int SBW       = 2;
    localparam int SLAVE_MAX = 2;
    localparam int MEM_WORDS = 512;
    localparam int TIMEOUT   = 2000;
    localparam int NUM_OPS   = 300;

    logic clk;
    logic reset;

    logic                  m_rd_read;
    rd_req_t               m_rd_req;
    logic [MBW-1:0]        m_rd_burstcount;
    logic                  m_rd_waitrequest;
    logic [DATA_WIDTH-1:0] m_rd_readdata;
    logic                  m_rd_readdatavalid;
    logic                  m_wr_write;
    logic [ADDR_WIDTH-1:0] m_wr_address;
    logic [MBW-1:0]        m_wr_burstcount;
    wr_beat_t              m_wr_beat;
    logic                  m_wr_waitrequest;
    logic                  m_wr_writeresponsevalid;
    logic                  s_rd_read;
    rd_req_t               s_rd_req;
    logic [SBW-1:0]        s_rd_burstcount;
    logic                  s_rd_waitrequest;
    logic [DATA_WIDTH-1:0] s_rd_readdata;
    logic                  s_rd_readdatavalid;
    logic                  s_wr_write;
    logic [ADDR_WIDTH-1:0] s_wr_address;
    logic [SBW-1:0]        s_wr_burstcount;
    wr_beat_t              s_wr_beat;
    logic                  s_wr_waitrequest;
    logic                  s_wr_writeresponsevalid;

    // Slave memory written by the bus, and the model written by the stimulus
    logic [31:0] mem       [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] rd_exp    [$];
    logic [8:0]  rd_beats  [$];

    logic [16:0]           lfsr_state = 17'd68674;
    logic [ADDR_WIDTH-1:0] exp_rd_addr;
    logic [3:0]            exp_rd_be;
    logic [ADDR_WIDTH-1:0] exp_wr_addr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    int                    wr_left;
    int                    pending_resp;
    int                    resp_count;
    int                    exp_resp;

    burst_map_top
    #(
        .MASTER_BURST_WIDTH (MBW),
        .SLAVE_BURST_WIDTH  (SBW),
        .NATURAL_ALIGNMENT  (1),
        .RESP_FIFO_DEPTH    (16)
    )
    DUT
    (
        .*
    );

    // Fibonacci LFSR on x^17 + x^14 + 1 that steps once per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Byte lanes with their enable set take the new data
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                r[8*b +: 8] = data[8*b +: 8];
        return r;
    endfunction

    task automatic fail_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "simulation stopped");
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory slave outputs change 1 ns after each rising edge
    initial
    begin
        s_rd_waitrequest = 1'b1;
        s_wr_waitrequest = 1'b1;
        s_rd_readdata = '0;
        s_rd_readdatavalid = 1'b0;
        s_wr_writeresponsevalid = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            // Three cycles in four stall, which keeps the bridge under pressure
            s_rd_waitrequest = (rand_bits(2) != 0);
            s_wr_waitrequest = (rand_bits(2) != 0);
            s_rd_readdatavalid = 1'b0;
            if (rd_beats.size() > 0 && rand_bits(1) == 1'b1)
            begin
                s_rd_readdatavalid = 1'b1;
                s_rd_readdata = mem[rd_beats.pop_front()];
            end
            s_wr_writeresponsevalid = 1'b0;
            if (pending_resp > 0 && rand_bits(1) == 1'b1)
            begin
                s_wr_writeresponsevalid = 1'b1;
                pending_resp--;
            end
        end
    end

    // Bus monitor sampling at the falling edge where every signal is settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (s_rd_read && !s_rd_waitrequest)
            begin
                if (s_rd_burstcount == '0 || int'(s_rd_burstcount) > SLAVE_MAX)
                    fail_run("slave read burst count is out of range");
                if (s_rd_burstcount == 2'd2 && s_rd_req.address[0])
                    fail_run("slave read burst is not aligned to its size");
                check_value("s_rd_req.address", 32'(s_rd_req.address), 32'(exp_rd_addr));
                check_value("s_rd_req.byteenable", 32'(s_rd_req.byteenable),
                            32'(exp_rd_be));
                for (int j = 0; j < int'(s_rd_burstcount); j++)
                    rd_beats.push_back(9'(s_rd_req.address + ADDR_WIDTH'(j)));
                exp_rd_addr = exp_rd_addr + ADDR_WIDTH'(s_rd_burstcount);
            end
            if (m_rd_readdatavalid)
            begin
                if (rd_exp.size() == 0)
                    fail_run("read data arrived with no read outstanding");
                check_value("m_rd_readdata", m_rd_readdata, rd_exp.pop_front());
            end
            if (s_wr_write && !s_wr_waitrequest)
            begin
                if (s_wr_burstcount != '0)
                begin
                    if (wr_left != 0)
                        fail_run("slave write burst started inside another burst");
                    if (int'(s_wr_burstcount) > SLAVE_MAX)
                        fail_run("slave write burst count is out of range");
                    if (s_wr_burstcount == 2'd2 && s_wr_address[0])
                        fail_run("slave write burst is not aligned to its size");
                    check_value("s_wr_address", 32'(s_wr_address), 32'(exp_wr_addr));
                    wr_addr = s_wr_address;
                    wr_left = int'(s_wr_burstcount);
                    exp_wr_addr = exp_wr_addr + ADDR_WIDTH'(s_wr_burstcount);
                end
                else if (wr_left == 0)
                    fail_run("slave write beat arrived outside any burst");
                mem[wr_addr[8:0]] = merge(mem[wr_addr[8:0]], s_wr_beat.writedata,
                                          s_wr_beat.byteenable);
                wr_addr++;
                wr_left--;
                // The slave answers each of its own bursts once
                if (wr_left == 0)
                    pending_resp++;
            end
            if (m_wr_writeresponsevalid)
                resp_count++;
        end
    end

    task automatic read_burst(input logic [ADDR_WIDTH-1:0] addr, input int cnt);
        logic [3:0] be;
        int         t;
        for (int i = 0; i < cnt; i++)
            rd_exp.push_back(model_mem[9'(addr + ADDR_WIDTH'(i))]);
        exp_rd_addr = addr;
        be = 4'(rand_bits(4));
        exp_rd_be = be;
        @(posedge clk);
        #1;
        m_rd_read = 1'b1;
        m_rd_req = '{address: addr, byteenable: be};
        m_rd_burstcount = MBW'(cnt);
        t = 0;
        @(negedge clk);
        while (m_rd_waitrequest)
        begin
            if (t == TIMEOUT)
                fail_run("master read request was never accepted");
            t++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        m_rd_read = 1'b0;
        t = 0;
        while (rd_exp.size() != 0)
        begin
            if (t == TIMEOUT)
                fail_run("read burst did not return all its beats");
            t++;
            @(posedge clk);
        end
    endtask

    task automatic write_burst(input logic [ADDR_WIDTH-1:0] addr, input int cnt);
        logic [31:0] data;
        logic [3:0]  be;
        int          t;
        exp_wr_addr = addr;
        exp_resp++;
        for (int i = 0; i < cnt; i++)
        begin
            data = rand_bits(32);
            be = 4'(rand_bits(4));
            model_mem[9'(addr + ADDR_WIDTH'(i))] =
                merge(model_mem[9'(addr + ADDR_WIDTH'(i))], data, be);
            @(posedge clk);
            #1;
            m_wr_write = 1'b1;
            m_wr_address = (i == 0) ? addr : '0;
            m_wr_burstcount = (i == 0) ? MBW'(cnt) : '0;
            m_wr_beat = '{writedata: data, byteenable: be};
            t = 0;
            @(negedge clk);
            while (m_wr_waitrequest)
            begin
                if (t == TIMEOUT)
                    fail_run("master write beat was never accepted");
                t++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        m_wr_write = 1'b0;
        t = 0;
        while (resp_count < exp_resp)
        begin
            if (t == TIMEOUT)
                fail_run("master write response never arrived");
            t++;
            @(posedge clk);
        end
        check_value("write response count", 32'(resp_count), 32'(exp_resp));
    endtask

    initial
    begin
        logic [1:0]            op;
        logic [ADDR_WIDTH-1:0] addr;
        int                    cnt;
        int                    t;
        reset = 1'b1;
        m_rd_read = 1'b0;
        m_rd_req = '0;
        m_rd_burstcount = '0;
        m_wr_write = 1'b0;
        m_wr_address = '0;
        m_wr_burstcount = '0;
        m_wr_beat = '0;
        wr_left = 0;
        pending_resp = 0;
        resp_count = 0;
        exp_resp = 0;
        exp_rd_addr = '0;
        exp_rd_be = '0;
        exp_wr_addr = '0;
        wr_addr = '0;
        // Fill depends on every address bit so misdirected reads show up
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = 32'h5a3c_0000 ^ (32'(i) * 32'h9e37_79b1);
            model_mem[i] = mem[i];
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("s_rd_read", 32'(s_rd_read), 32'd0);
        check_value("s_wr_write", 32'(s_wr_write), 32'd0);
        check_value("m_wr_writeresponsevalid", 32'(m_wr_writeresponsevalid), 32'd0);
        repeat (NUM_OPS)
        begin
            @(negedge clk);
            op = 2'(rand_bits(2));
            addr = ADDR_WIDTH'(rand_bits(8));
            cnt = int'(rand_bits(3)) + 1;
            if (op < 2)
                write_burst(addr, cnt);
            else
                read_burst(addr, cnt);
        end
        t = 0;
        while (pending_resp != 0)
        begin
            if (t == TIMEOUT)
                fail_run("slave write responses still pending at the end");
            t++;
            @(posedge clk);
        end
        // Idle cycles let any extra response or read beat show up
        repeat (20) @(posedge clk);
        check_value("write response count", 32'(resp_count), 32'(exp_resp));
        check_value("outstanding read beats", 32'(rd_beats.size()), 32'd0);
        for (int i = 0; i < MEM_WORDS; i++)
            check_value($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb.f
hw/burst_map_pkg.sv
hw/sop_tracker.sv
hw/burst_gearbox.sv
hw/burst_remap.sv
hw/wr_resp_filter.sv
hw/burst_map_top.sv
sim/burst_map_assert.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the burst mapping bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f tb.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
